// ==== filelist.f ====
source/tcm_pkg.sv
source/sim_ram.sv
source/lsu_align.sv
source/tcm_arbiter.sv
source/tcm_top.sv
tb/tcm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# verilator build and run of the tcm testbench
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tcm_tb -f filelist.f --Mdir obj_dir -o tcm_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tcm_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log
if grep -q '\*\* FAIL \*\*' "$log"; then
    exit 1
fi
exit 0

// ==== tb/tcm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tcm_tb;
    import tcm_pkg::*;

    // what the dut should show in one cycle
    typedef struct packed {
        data_rsp_t   rsp;
        logic        fetch_valid;
        logic [31:0] instr;
        logic        stall;      // same cycle as the request
    } expect_t;

    localparam int n_iter     = 32;
    localparam int n_prog     = 64;   // program words loaded into itcm
    localparam int n_drain    = 2;
    localparam int max_cycles = 4 * (7 + 2 * tcm_depth + 32 * n_iter + 2 * n_prog + 6 * n_drain);

    logic        clk;
    logic        rst_n;
    logic        fetch_req;
    logic [31:0] fetch_pc;
    data_req_t   data_req;
    logic [31:0] fetch_instr;
    logic        fetch_rvalid;
    logic        fetch_stall;
    data_rsp_t   data_rsp;

    logic [31:0] itcm_model [tcm_depth];  // reference contents
    logic [31:0] dtcm_model [tcm_depth];
    logic [31:0] lcg_state;
    logic [31:0] addr_q [$];             // word test addresses
    expect_t     exp_now;                // due in this cycle
    expect_t     exp_next;               // from this cycle's request
    logic        checking;
    int          errors;
    int          checks;
    int          err_mark;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt = 0;

    tcm_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc),
        .data_req     (data_req),
        .fetch_instr  (fetch_instr),
        .fetch_rvalid (fetch_rvalid),
        .fetch_stall  (fetch_stall),
        .data_rsp     (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // random numbers
    // ====================
    function automatic logic [15:0] lcg_step();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];  // low bits have short periods
    endfunction

    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = lcg_step();
        lo = lcg_step();
        return {hi, lo};
    endfunction

    // aligned word address somewhere in a region
    function automatic logic [31:0] rand_in(logic [31:0] base);
        logic [31:0] r;
        r = rand32();
        return base + 32'({r[tcm_aw+1:2], 2'b00});
    endfunction

    function automatic logic [31:0] pick_base();
        logic [31:0] r;
        r = rand32();
        return r[31] ? dtcm_base : itcm_base;
    endfunction

    // fill pattern, every address bit matters
    function automatic logic [31:0] fill_word(logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ 32'h6a09_e667;
    endfunction

    // ====================
    // reference model
    // ====================
    function automatic region_e region_of(logic [31:0] a);
        if (a - itcm_base < tcm_size_bytes) return region_itcm;
        if (a - dtcm_base < tcm_size_bytes) return region_dtcm;
        return region_none;
    endfunction

    function automatic int size_of(lsu_width_e w);
        case (w)
            lsu_b, lsu_bu: return 1;
            lsu_h, lsu_hu: return 2;
            default:       return 4;
        endcase
    endfunction

    // misaligned or unmapped
    function automatic logic refused(data_req_t r);
        return ((r.addr % size_of(r.width)) != 0) || (region_of(r.addr) == region_none);
    endfunction

    function automatic expect_t expected_result(data_req_t r, logic freq, logic [31:0] pc);
        expect_t     e;
        logic [31:0] word;
        logic [31:0] pick;
        int          lane;
        e    = '0;
        pick = '0;
        word = (region_of(r.addr) == region_itcm) ? itcm_model[r.addr[tcm_aw+1:2]]
                                                  : dtcm_model[r.addr[tcm_aw+1:2]];
        if (r.valid && refused(r)) begin
            e.rsp.valid = 1'b1;  // rdata stays zero
            e.rsp.fault = 1'b1;
        end else if (r.valid && !r.we) begin
            for (int i = 0; i < size_of(r.width); i++) begin
                lane = int'(r.addr[1:0]) + i;
                pick[8*i +: 8] = word[8*lane +: 8];  // gather lanes from the low byte up
            end
            e.rsp.valid = 1'b1;
            case (r.width)
                lsu_b:   e.rsp.rdata = {{24{pick[7]}}, pick[7:0]};
                lsu_h:   e.rsp.rdata = {{16{pick[15]}}, pick[15:0]};
                default: e.rsp.rdata = pick;  // unsigned and word, top already zero
            endcase
        end
        e.stall       = freq & r.valid & ~refused(r) & (region_of(r.addr) == region_itcm);
        e.fetch_valid = freq & ~e.stall;
        e.instr       = itcm_model[pc[tcm_aw+1:2]];
        return e;
    endfunction

    task automatic apply_store(data_req_t r);
        int lane;
        if (r.valid && r.we && !refused(r)) begin
            for (int i = 0; i < size_of(r.width); i++) begin
                lane = int'(r.addr[1:0]) + i;
                if (region_of(r.addr) == region_itcm)
                    itcm_model[r.addr[tcm_aw+1:2]][8*lane +: 8] = r.wdata[8*i +: 8];
                else
                    dtcm_model[r.addr[tcm_aw+1:2]][8*lane +: 8] = r.wdata[8*i +: 8];
            end
        end
    endtask

    // ====================
    // stimulus helpers
    // ====================
    function automatic data_req_t mk_req(logic we, lsu_width_e w, logic [31:0] a,
                                         logic [31:0] d);
        data_req_t r;
        r.valid = 1'b1;
        r.we    = we;
        r.width = w;
        r.addr  = a;
        r.wdata = d;
        return r;
    endfunction

    // one cycle, inputs change 1 ns after the edge
    task automatic issue(data_req_t r, logic freq, logic [31:0] pc);
        @(posedge clk);
        #1;
        exp_now   = exp_next;
        exp_next  = expected_result(r, freq, pc);  // before the store lands
        apply_store(r);
        data_req  = r;
        fetch_req = freq;
        fetch_pc  = pc;
    endtask

    task automatic drain();
        repeat (n_drain) issue('0, 1'b0, 32'd0);
    endtask

    task automatic report_test(string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s done, ok", name);
        end else begin
            tests_failed++;
            $display("test %s done, %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ====================
    // comparison
    // ====================
    always @(negedge clk) begin
        if (checking) begin
            checks++;
            assert (data_rsp.valid === exp_now.rsp.valid
                    && data_rsp.fault === exp_now.rsp.fault) else begin
                errors++;
                $display("error at %0t: data_rsp valid %b fault %b, expected %b %b", $time,
                         data_rsp.valid, data_rsp.fault, exp_now.rsp.valid, exp_now.rsp.fault);
            end
            assert (!exp_now.rsp.valid || data_rsp.rdata === exp_now.rsp.rdata) else begin
                errors++;
                $display("error at %0t: rdata %h, expected %h", $time,
                         data_rsp.rdata, exp_now.rsp.rdata);
            end
            assert (fetch_rvalid === exp_now.fetch_valid) else begin
                errors++;
                $display("error at %0t: fetch_rvalid %b, expected %b", $time,
                         fetch_rvalid, exp_now.fetch_valid);
            end
            assert (!exp_now.fetch_valid || fetch_instr === exp_now.instr) else begin
                errors++;
                $display("error at %0t: fetch_instr %h, expected %h", $time,
                         fetch_instr, exp_now.instr);
            end
            assert (fetch_stall === exp_next.stall) else begin  // combinational, this cycle
                errors++;
                $display("error at %0t: fetch_stall %b, expected %b", $time,
                         fetch_stall, exp_next.stall);
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // ====================
    // test sequence
    // ====================
    initial begin
        logic [31:0] a;
        rst_n        = 1'b0;
        fetch_req    = 1'b0;
        fetch_pc     = '0;
        data_req     = '0;
        lcg_state    = 32'd38878;
        exp_now      = '0;
        exp_next     = '0;
        checking     = 1'b0;
        errors       = 0;
        checks       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        checking = 1'b1;

        repeat (4) issue('0, 1'b0, 32'd0);  // outputs quiet after reset
        report_test("reset");

        for (int i = 0; i < tcm_depth; i++) begin
            issue(mk_req(1'b1, lsu_w, itcm_base + 4 * i, fill_word(itcm_base + 4 * i)), 1'b0, 0);
            issue(mk_req(1'b1, lsu_w, dtcm_base + 4 * i, fill_word(dtcm_base + 4 * i)), 1'b0, 0);
        end
        drain();
        report_test("fill");

        for (int i = 0; i < n_iter; i++) begin
            a = rand_in(pick_base());
            addr_q.push_back(a);
            issue(mk_req(1'b1, lsu_w, a, rand32()), 1'b0, 32'd0);
        end
        foreach (addr_q[i]) issue(mk_req(1'b0, lsu_w, addr_q[i], 32'd0), 1'b0, 32'd0);
        drain();
        report_test("word");

        for (int i = 0; i < n_iter; i++) begin
            a = rand_in(pick_base());
            for (int k = 0; k < 4; k++) issue(mk_req(1'b1, lsu_b, a + k, rand32()), 1'b0, 0);
            for (int k = 0; k < 4; k++) issue(mk_req(1'b0, lsu_b, a + k, 32'd0), 1'b0, 0);
            for (int k = 0; k < 4; k++) issue(mk_req(1'b0, lsu_bu, a + k, 32'd0), 1'b0, 0);
            for (int k = 0; k < 4; k += 2) issue(mk_req(1'b1, lsu_h, a + k, rand32()), 1'b0, 0);
            for (int k = 0; k < 4; k += 2) issue(mk_req(1'b0, lsu_h, a + k, 32'd0), 1'b0, 0);
            for (int k = 0; k < 4; k += 2) issue(mk_req(1'b0, lsu_hu, a + k, 32'd0), 1'b0, 0);
            issue(mk_req(1'b0, lsu_w, a, 32'd0), 1'b0, 32'd0);
        end
        drain();
        report_test("subword");

        for (int i = 0; i < n_iter; i++) begin
            a = rand_in(pick_base());
            issue(mk_req(1'b1, lsu_w, a + 1, rand32()), 1'b0, 32'd0);   // misaligned
            issue(mk_req(1'b1, lsu_h, a + 3, rand32()), 1'b0, 32'd0);
            issue(mk_req(1'b0, lsu_h, a + 1, 32'd0), 1'b0, 32'd0);
            issue(mk_req(1'b0, lsu_w, a + 2, 32'd0), 1'b0, 32'd0);
            issue(mk_req(1'b1, lsu_w, a | tcm_size_bytes, rand32()), 1'b0, 32'd0);  // unmapped
            issue(mk_req(1'b1, lsu_b, a | 32'h8000_0000, rand32()), 1'b0, 32'd0);
            issue(mk_req(1'b0, lsu_w, a, 32'd0), 1'b0, 32'd0);  // word must be untouched
        end
        drain();
        report_test("fault");

        for (int i = 0; i < n_prog; i++) issue(mk_req(1'b1, lsu_w, 4 * i, rand32()), 1'b0, 0);
        for (int i = 0; i < n_prog; i++) issue('0, 1'b1, 4 * i);  // back to back fetch
        drain();
        report_test("program");

        for (int i = 0; i < n_iter; i++) begin
            issue(mk_req(1'b0, lsu_w, rand_in(itcm_base), 32'd0), 1'b1, rand_in(itcm_base));
            issue(mk_req(1'b1, lsu_w, rand_in(itcm_base), rand32()), 1'b1, rand_in(itcm_base));
            issue(mk_req(1'b0, lsu_w, rand_in(dtcm_base), 32'd0), 1'b1, rand_in(itcm_base));
            issue(mk_req(1'b1, lsu_w, rand_in(dtcm_base), rand32()), 1'b1, rand_in(itcm_base));
        end
        drain();
        report_test("collide");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/tcm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// tightly coupled memories for a small rv32i core
// fetch port on itcm, load/store port on both
module tcm_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        fetch_req,
    input  wire [31:0]                 fetch_pc,
    input  wire tcm_pkg::data_req_t    data_req,
    output logic [tcm_pkg::xlen-1:0]   fetch_instr,
    output logic                       fetch_rvalid,
    output logic                       fetch_stall,
    output tcm_pkg::data_rsp_t         data_rsp
);
    import tcm_pkg::*;

    // aligner to arbiter
    ram_req_t        align_req;
    logic [31:0]     byte_addr;
    logic            access;
    logic            misaligned;

    // arbiter to rams and back
    ram_req_t        itcm_req;
    ram_req_t        dtcm_req;
    logic [xlen-1:0] itcm_dout;
    logic [xlen-1:0] dtcm_dout;

    // arbiter to aligner
    logic [xlen-1:0] raw_rdata;
    logic            raw_valid;
    logic            raw_fault;

    // ====================
    // load/store alignment
    // ====================
    lsu_align u_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_req   (data_req),
        .ram_req    (align_req),
        .byte_addr  (byte_addr),
        .access     (access),
        .misaligned (misaligned),
        .raw_rdata  (raw_rdata),
        .raw_valid  (raw_valid),
        .raw_fault  (raw_fault),
        .data_rsp   (data_rsp)
    );

    // ====================
    // decode and arbitration
    // ====================
    tcm_arbiter u_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc),
        .ram_req      (align_req),
        .byte_addr    (byte_addr),
        .access       (access),
        .misaligned   (misaligned),
        .itcm_req     (itcm_req),
        .dtcm_req     (dtcm_req),
        .itcm_dout    (itcm_dout),
        .dtcm_dout    (dtcm_dout),
        .fetch_instr  (fetch_instr),
        .fetch_rvalid (fetch_rvalid),
        .fetch_stall  (fetch_stall),
        .raw_rdata    (raw_rdata),
        .raw_valid    (raw_valid),
        .raw_fault    (raw_fault)
    );

    // ====================
    // memories
    // ====================
    sim_ram #(
        .depth        (tcm_depth),
        .force_x2zero (1'b0)       // itcm shows raw contents
    ) u_itcm (
        .clk  (clk),
        .req  (itcm_req),
        .dout (itcm_dout)
    );

    sim_ram #(
        .depth        (tcm_depth),
        .force_x2zero (1'b1)       // unwritten data words read as zero
    ) u_dtcm (
        .clk  (clk),
        .req  (dtcm_req),
        .dout (dtcm_dout)
    );

endmodule

`default_nettype wire

// ==== source/tcm_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// region decode and port steering for itcm / dtcm
// data wins the itcm port, fetch is stalled for that cycle
module tcm_arbiter (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        fetch_req,
    input  wire [31:0]                 fetch_pc,
    input  wire tcm_pkg::ram_req_t     ram_req,
    input  wire [31:0]                 byte_addr,
    input  wire                        access,
    input  wire                        misaligned,
    output tcm_pkg::ram_req_t          itcm_req,
    output tcm_pkg::ram_req_t          dtcm_req,
    input  wire [tcm_pkg::xlen-1:0]    itcm_dout,
    input  wire [tcm_pkg::xlen-1:0]    dtcm_dout,
    output logic [tcm_pkg::xlen-1:0]   fetch_instr,
    output logic                       fetch_rvalid,
    output logic                       fetch_stall,
    output logic [tcm_pkg::xlen-1:0]   raw_rdata,
    output logic                       raw_valid,
    output logic                       raw_fault
);
    import tcm_pkg::*;

    region_e region;
    logic    data_ok;      // access that reaches a ram
    logic    data_fault;   // refused access
    logic    data_itcm;
    logic    data_dtcm;
    logic    is_load;
    logic    fetch_grant;
    logic    ld_itcm_q;    // load in flight from itcm
    logic    ld_dtcm_q;    // load in flight from dtcm

    // ====================
    // decode
    // ====================
    // regions are size aligned, compare the bits above the offset
    always_comb begin
        if (byte_addr[xlen-1:tcm_off_w] == itcm_base[xlen-1:tcm_off_w]) begin
            region = region_itcm;
        end else if (byte_addr[xlen-1:tcm_off_w] == dtcm_base[xlen-1:tcm_off_w]) begin
            region = region_dtcm;
        end else begin
            region = region_none;
        end
    end

    assign data_ok    = access & ~misaligned & (region != region_none);
    assign data_fault = access & (misaligned | (region == region_none));
    assign data_itcm  = data_ok & (region == region_itcm);
    assign data_dtcm  = data_ok & (region == region_dtcm);
    assign is_load    = ~ram_req.we;

    // collision on the itcm port
    assign fetch_stall = fetch_req & data_itcm;
    assign fetch_grant = fetch_req & ~data_itcm;

    // ====================
    // ram ports
    // ====================
    always_comb begin
        if (data_itcm) begin
            itcm_req = ram_req;                      // data access owns the port
        end else begin
            itcm_req.we    = 1'b0;                   // fetch is read only
            itcm_req.wem   = '0;
            itcm_req.addr  = fetch_pc[tcm_aw+1:2];   // pc word index
            itcm_req.wdata = ram_req.wdata;          // ignored on a read
        end
    end

    // dtcm sees data only, idle cycles are plain reads
    always_comb begin
        dtcm_req       = ram_req;
        dtcm_req.we    = data_dtcm & ram_req.we;
        dtcm_req.wem   = data_dtcm ? ram_req.wem : '0;
    end

    // ====================
    // response steering
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_itcm_q    <= 1'b0;
            ld_dtcm_q    <= 1'b0;
            fetch_rvalid <= 1'b0;
            raw_fault    <= 1'b0;
        end else begin
            ld_itcm_q    <= data_itcm & is_load;
            ld_dtcm_q    <= data_dtcm & is_load;
            fetch_rvalid <= fetch_grant;
            raw_fault    <= data_fault;  // never wrote, just report
        end
    end

    assign fetch_instr = itcm_dout;  // qualified by fetch_rvalid
    assign raw_valid   = ld_itcm_q | ld_dtcm_q;
    assign raw_rdata   = ld_itcm_q ? itcm_dout : dtcm_dout;

endmodule

`default_nettype wire

// ==== source/lsu_align.sv ====
`timescale 1ns/1ps
`default_nettype none

// rv32i load/store alignment
// request side places store lanes and builds the byte mask
// response side picks the addressed bytes and extends them
module lsu_align (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire tcm_pkg::data_req_t    data_req,
    output tcm_pkg::ram_req_t          ram_req,
    output logic [31:0]                byte_addr,
    output logic                       access,
    output logic                       misaligned,
    input  wire [tcm_pkg::xlen-1:0]    raw_rdata,
    input  wire                        raw_valid,
    input  wire                        raw_fault,
    output tcm_pkg::data_rsp_t         data_rsp
);
    import tcm_pkg::*;

    logic [1:0]        off;        // byte offset in word
    logic              is_byte;
    logic              is_half;
    logic              is_word;
    logic [xlen-1:0]   st_data;    // store data placed on lanes
    logic [mask_w-1:0] st_mask;

    lsu_width_e        ld_width_q; // width of the load in flight
    logic [1:0]        ld_off_q;   // its byte offset
    logic [xlen-1:0]   shifted;
    logic [xlen-1:0]   ext;

    // ====================
    // request side
    // ====================
    assign off       = data_req.addr[1:0];
    assign byte_addr = data_req.addr;
    assign access    = data_req.valid;

    // size class, signed and unsigned share a size
    always_comb begin
        is_byte = 1'b0;
        is_half = 1'b0;
        case (data_req.width)
            lsu_b, lsu_bu: is_byte = 1'b1;
            lsu_h, lsu_hu: is_half = 1'b1;
            default:       ;  // word, and unused codes act as word
        endcase
    end

    assign is_word = ~is_byte & ~is_half;

    // halfword on odd byte, word off a 4 byte boundary
    assign misaligned = data_req.valid & ((is_half & off[0]) | (is_word & (|off)));

    // lane replication and mask
    always_comb begin
        if (is_byte) begin
            st_data = {mask_w{data_req.wdata[7:0]}};      // byte on all lanes
            st_mask = mask_w'(1) << off;
        end else if (is_half) begin
            st_data = {2{data_req.wdata[15:0]}};          // half on both halves
            st_mask = mask_w'(2'b11) << {off[1], 1'b0};   // upper or lower pair
        end else begin
            st_data = data_req.wdata;
            st_mask = '1;
        end
    end

    always_comb begin
        ram_req.we    = data_req.valid & data_req.we;
        ram_req.wem   = st_mask;
        ram_req.addr  = data_req.addr[tcm_aw+1:2];  // word index inside region
        ram_req.wdata = st_data;
    end

    // ====================
    // response side
    // ====================
    // remember how to slice the word that comes back next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_width_q <= lsu_w;
            ld_off_q   <= 2'b00;
        end else if (data_req.valid && !data_req.we) begin
            ld_width_q <= data_req.width;
            ld_off_q   <= off;
        end
    end

    // addressed byte or half down to bit 0
    assign shifted = raw_rdata >> {ld_off_q, 3'b000};

    always_comb begin
        case (ld_width_q)
            lsu_b:   ext = {{(xlen-8){shifted[7]}}, shifted[7:0]};     // sign
            lsu_bu:  ext = {{(xlen-8){1'b0}}, shifted[7:0]};
            lsu_h:   ext = {{(xlen-16){shifted[15]}}, shifted[15:0]};  // sign
            lsu_hu:  ext = {{(xlen-16){1'b0}}, shifted[15:0]};
            default: ext = raw_rdata;                                  // full word
        endcase
    end

    // fault pulse also answers a store
    always_comb begin
        data_rsp.valid = raw_valid | raw_fault;
        data_rsp.fault = raw_fault;
        data_rsp.rdata = raw_fault ? '0 : ext;
    end

endmodule

`default_nettype wire

// ==== source/sim_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// byte masked single port sram model
// read address is registered, so data shows one cycle later
module sim_ram #(
    parameter int unsigned depth        = tcm_pkg::tcm_depth,
    parameter bit          force_x2zero = 1'b0
) (
    input  wire                        clk,
    input  wire tcm_pkg::ram_req_t     req,
    output logic [tcm_pkg::xlen-1:0]   dout
);
    import tcm_pkg::*;

    // ====================
    // storage
    // ====================
    logic [xlen-1:0]   mem [depth];  // no init, contents start undefined
    logic [tcm_aw-1:0] rd_addr_q;    // last read address
    logic [xlen-1:0]   dout_pre;     // raw array output

    // byte lane writes
    always_ff @(posedge clk) begin
        for (int l = 0; l < mask_w; l++) begin
            if (req.we && req.wem[l]) begin
                mem[req.addr][8*l +: 8] <= req.wdata[8*l +: 8];  // lane l only
            end
        end
    end

    // read address only moves on read cycles
    // so dout keeps the last read word through a write
    always_ff @(posedge clk) begin
        if (!req.we) begin
            rd_addr_q <= req.addr;
        end
    end

    assign dout_pre = mem[rd_addr_q];

    // ====================
    // output stage
    // ====================
    generate
        if (force_x2zero) begin : g_x2zero
            // unknown or floating bits read back as zero
            always_comb begin
                for (int i = 0; i < xlen; i++) begin
                    dout[i] = (dout_pre[i] === 1'b1);
                end
            end
        end else begin : g_raw
            assign dout = dout_pre;  // pass array word as is
        end
    endgenerate

endmodule

`default_nettype wire

// ==== source/tcm_pkg.sv ====
`default_nettype none

package tcm_pkg;

    // ====================
    // widths
    // ====================
    localparam int unsigned xlen      = 32;                // data word
    localparam int unsigned mask_w    = xlen / 8;          // byte lanes per word
    localparam int unsigned tcm_depth = 512;               // words per memory
    localparam int unsigned tcm_aw    = $clog2(tcm_depth); // word address bits
    localparam int unsigned tcm_off_w = tcm_aw + 2;        // byte offset bits inside a region

    // ====================
    // address map
    // ====================
    localparam logic [xlen-1:0] itcm_base      = 32'h0000_0000;
    localparam logic [xlen-1:0] dtcm_base      = 32'h0001_0000;
    localparam int unsigned     tcm_size_bytes = tcm_depth * mask_w; // 2 KiB per region

    // decoded target of a data access
    typedef enum logic [1:0] {
        region_itcm,
        region_dtcm,
        region_none    // decode miss, refused with a fault
    } region_e;

    // load/store width, same codes as rv32i funct3
    typedef enum logic [2:0] {
        lsu_b  = 3'b000,
        lsu_h  = 3'b001,
        lsu_w  = 3'b010,
        lsu_bu = 3'b100,
        lsu_hu = 3'b101
    } lsu_width_e;

    // ====================
    // request / response
    // ====================
    // data port request from the core side
    typedef struct packed {
        logic             valid;  // one-cycle strobe
        logic             we;     // store when set
        lsu_width_e       width;
        logic [31:0]      addr;   // byte address
        logic [xlen-1:0]  wdata;  // store data, right aligned
    } data_req_t;

    // word level request into one ram
    typedef struct packed {
        logic              we;
        logic [mask_w-1:0] wem;   // byte lane enables
        logic [tcm_aw-1:0] addr;  // word address
        logic [xlen-1:0]   wdata; // lane placed
    } ram_req_t;

    // data port response, one-cycle pulse
    typedef struct packed {
        logic            valid;
        logic            fault;   // misaligned or unmapped
        logic [xlen-1:0] rdata;   // extended load data, zero on fault
    } data_rsp_t;

endpackage

`default_nettype wire
